//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mpuReaderTb
FILELIST  = compile.f
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

//--- compile.f
+incdir+rtl
rtl/mpuReader_pkg.sv
rtl/i2cRegMaster.sv
rtl/mpuSampleSequencer.sv
rtl/mpuReaderTop.sv
dv/mpuSensorModel.sv
dv/mpuReader_props.sv
dv/mpuReaderTb.sv

//--- dv/mpuReaderTb.sv
// Motion sensor reader testbench
`include "mpuReader_cfg.svh"

module mpuReaderTb;

    localparam int waitLimit = 60000;   // clocks for one full sample round

    logic                       I_Clk_in;
    logic                       I_Rst_n;
    logic                       scl;
    logic                       dutPull;
    logic                       sensorPull;
    logic                       sda;
    logic                       sampleValid;
    logic                       sampleReady;
    logic                       ackEnable;
    mpuReader_pkg::accelSampleT sample;
    mpuReader_pkg::accelSampleT expected;
    integer                     seed;
    int                         failCount;
    int                         testsRun;
    int                         testsFailed;
    int                         failsBefore;

    assign sda = ~dutPull & ~sensorPull;                 // open drain wired-and

    mpuReaderTop dut0
    (
        .I_Clk_in    (I_Clk_in),
        .I_Rst_n     (I_Rst_n),
        .scl         (scl),
        .sdaPullLow  (dutPull),
        .sdaIn       (sda),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .sample      (sample)
    );

    mpuSensorModel sensor0
    (
        .I_Clk_in   (I_Clk_in),
        .I_Rst_n    (I_Rst_n),
        .scl        (scl),
        .sda        (sda),
        .ackEnable  (ackEnable),
        .sdaPullLow (sensorPull)
    );

    initial
    begin
        I_Clk_in = 1'b0;
        forever #4 I_Clk_in = ~I_Clk_in;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    // six bytes from 0x3B on, high byte of each axis first
    function automatic mpuReader_pkg::accelSampleT expSample(input logic [47:0] raw,
                                                              input logic nacked);
        mpuReader_pkg::accelSampleT s;
        s.accX = mpuReader_pkg::axisT'({raw[47:40], raw[39:32]});
        s.accY = mpuReader_pkg::axisT'({raw[31:24], raw[23:16]});
        s.accZ = mpuReader_pkg::axisT'({raw[15:8], raw[7:0]});
        s.err  = nacked;
        return s;
    endfunction

    function automatic logic [47:0] accelBytes();
        logic [47:0] raw;
        raw = '0;
        for (int i = 0; i < `MPU_ACCEL_BYTES; i++)
        begin
            raw = {raw[39:0], sensor0.regs[`MPU_REG_ACCEL + i]};
        end
        return raw;
    endfunction

    task automatic loadAccelRegs();
        @(negedge I_Clk_in);
        for (int i = 0; i < `MPU_ACCEL_BYTES; i++)
        begin
            sensor0.regs[`MPU_REG_ACCEL + i] <= 8'($random(seed));
        end
        @(posedge I_Clk_in);                             // new bytes settled
    endtask

    ////////////////////////////////////////
    // handshake helpers
    ////////////////////////////////////////
    task automatic waitSample(input string name);
        int cnt;
        cnt = 0;
        @(negedge I_Clk_in);
        while (!sampleValid)
        begin
            cnt++;
            if (cnt > waitLimit)
            begin
                $display("%s: no sample delivered within %0d clocks", name, waitLimit);
                $display("TEST FAILED");
                $finish;
            end
            @(negedge I_Clk_in);
        end
    endtask

    task automatic acceptSample();
        @(posedge I_Clk_in);
        sampleReady <= 1'b1;
        @(posedge I_Clk_in);
        sampleReady <= 1'b0;                             // taken on this edge
    endtask

    task automatic checkSample(input string name, input mpuReader_pkg::accelSampleT exp);
        assert (sample == exp)
        else
        begin
            $display("FAIL %s expected %h actual %h", name, exp, sample);
            failCount++;
        end
    endtask

    // stall the output, sample and bus must stay quiet
    task automatic holdAndCheck(input string name);
        mpuReader_pkg::accelSampleT held;
        int hold;
        held = sample;
        hold = $unsigned($random(seed)) % 201;
        repeat (hold)
        begin
            @(negedge I_Clk_in);
            assert (sampleValid && sample == held)
            else
            begin
                $display("FAIL %s expected %h actual %h", name, held, sample);
                failCount++;
            end
            assert (scl && !dutPull)
            else
            begin
                $display("%s: bus activity while the sample was held", name);
                failCount++;
            end
        end
    endtask

    task automatic beginTest();
        failsBefore = failCount;
        testsRun++;
    endtask

    task automatic endTest(input string name);
        if (failCount == failsBefore)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: failed", name);
            testsFailed++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus and compare
    ////////////////////////////////////////
    initial
    begin
        seed        = 78;
        failCount   = 0;
        testsRun    = 0;
        testsFailed = 0;
        I_Rst_n     = 1'b0;
        sampleReady = 1'b0;
        ackEnable   = 1'b1;
        for (int i = 0; i < 128; i++)
        begin
            sensor0.regs[i] <= 8'($random(seed));
        end
        sensor0.regs[`MPU_REG_PWR] <= 8'h40;             // asleep out of power up
        repeat (3) @(posedge I_Clk_in);
        I_Rst_n <= 1'b1;

        beginTest();
        waitSample("wake");
        assert (sensor0.regs[`MPU_REG_PWR] == 8'h00)
        else
        begin
            $display("FAIL wake expected 00 actual %h", sensor0.regs[`MPU_REG_PWR]);
            failCount++;
        end
        endTest("wake");

        beginTest();
        checkSample("first", expSample(accelBytes(), 1'b0));
        endTest("first");

        beginTest();
        holdAndCheck("backpressure");
        endTest("backpressure");

        beginTest();
        for (int it = 0; it < 10; it++)
        begin
            loadAccelRegs();
            expected = expSample(accelBytes(), 1'b0);
            acceptSample();
            waitSample("fresh");
            checkSample("fresh", expected);
            holdAndCheck("fresh");
        end
        endTest("fresh");

        beginTest();
        @(posedge I_Clk_in);
        ackEnable <= 1'b0;                               // whole round nacked
        acceptSample();
        waitSample("nack");
        assert (sample.err)
        else
        begin
            $display("FAIL nack expected err 1 actual err %b", sample.err);
            failCount++;
        end
        @(posedge I_Clk_in);
        ackEnable <= 1'b1;
        loadAccelRegs();
        expected = expSample(accelBytes(), 1'b0);
        acceptSample();
        waitSample("recover");
        checkSample("recover", expected);
        endTest("nack");

        beginTest();
        assert (dut0.props0.propFails == 0)
        else
        begin
            $display("bus or handshake properties failed %0d times", dut0.props0.propFails);
            failCount++;
        end
        endTest("properties");

        $display("tests %0d, failed %0d, failing checks %0d", testsRun, testsFailed, failCount);
        if (failCount == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/mpuReader_props.sv
// Reader bus and handshake properties
module mpuReader_props
(
    input logic                       I_Clk_in,
    input logic                       I_Rst_n,
    input logic                       scl,
    input logic                       sdaPullLow,
    input logic                       reqValid,
    input logic                       reqReady,
    input logic                       rspValid,
    input mpuReader_pkg::i2cReqT      req,
    input logic                       sampleValid,
    input logic                       sampleReady,
    input mpuReader_pkg::accelSampleT sample,
    input mpuReader_pkg::masterStateT mstState
);

    int propFails = 0;      // failed property count

    // sda only moves under high scl for start, restart or stop
    sdaWindow: assert property (@(posedge I_Clk_in) disable iff (!I_Rst_n)
        (scl && $past(scl) && $changed(sdaPullLow)) |->
        ($past(mstState) inside {mpuReader_pkg::start, mpuReader_pkg::restart,
                                 mpuReader_pkg::stop}))
        else
        begin
            $error("sda changed under high scl outside start or stop");
            propFails++;
        end

    reqHold: assert property (@(posedge I_Clk_in) disable iff (!I_Rst_n)
        (reqValid && !reqReady) |=> (reqValid && $stable(req)))
        else
        begin
            $error("request dropped or changed while stalled");
            propFails++;
        end

    sampleHold: assert property (@(posedge I_Clk_in) disable iff (!I_Rst_n)
        (sampleValid && !sampleReady) |=> (sampleValid && $stable(sample)))
        else
        begin
            $error("sample dropped or changed while stalled");
            propFails++;
        end

    // first edge out of reset
    resetQuiet: assert property (@(posedge I_Clk_in)
        $rose(I_Rst_n) |-> (!reqValid && !rspValid && !sampleValid && !sdaPullLow
                            && scl && reqReady))
        else
        begin
            $error("outputs active right after reset");
            propFails++;
        end

endmodule

bind mpuReaderTop mpuReader_props props0
(
    .I_Clk_in    (I_Clk_in),
    .I_Rst_n     (I_Rst_n),
    .scl         (scl),
    .sdaPullLow  (sdaPullLow),
    .reqValid    (reqValid),
    .reqReady    (reqReady),
    .rspValid    (rspValid),
    .req         (req),
    .sampleValid (sampleValid),
    .sampleReady (sampleReady),
    .sample      (sample),
    .mstState    (master0.state)
);

//--- dv/mpuSensorModel.sv
// Behavioral accelerometer I2C slave
`include "mpuReader_cfg.svh"

module mpuSensorModel
(
    input  logic I_Clk_in,
    input  logic I_Rst_n,
    input  logic scl,
    input  logic sda,              // resolved line
    input  logic ackEnable,        // low answers every byte with nack
    output logic sdaPullLow
);

    typedef enum logic [2:0] {pIdle, pAddr, pReg, pWrite, pRead} phaseT;

    logic [7:0] regs [128];        // register file, loaded by the testbench
    logic [7:0] ptr;               // auto advancing register pointer
    logic [7:0] rxByte;
    logic [7:0] txByte;
    logic [3:0] bitPos;            // scl rises seen in the current byte
    logic       sclQ;
    logic       sdaQ;
    logic       acked;
    phaseT      phase;

    always @(posedge I_Clk_in or negedge I_Rst_n)
    begin
        if (!I_Rst_n)
        begin
            sclQ       <= 1'b1;
            sdaQ       <= 1'b1;
            sdaPullLow <= 1'b0;
            phase      <= pIdle;
            bitPos     <= '0;
            ptr        <= '0;
            rxByte     <= '0;
            txByte     <= '0;
            acked      <= 1'b0;
        end
        else
        begin
            sclQ <= scl;
            sdaQ <= sda;
            if (sclQ && scl && sdaQ && !sda)
            begin
                phase      <= pAddr;                          // start or repeated start
                bitPos     <= '0;
                sdaPullLow <= 1'b0;
            end
            else if (sclQ && scl && !sdaQ && sda)
            begin
                phase      <= pIdle;                          // stop
                sdaPullLow <= 1'b0;
            end
            else if (!sclQ && scl && phase != pIdle)
            begin
                if (bitPos < 4'd8)
                begin
                    rxByte <= {rxByte[6:0], sda};             // msb first
                end
                bitPos <= bitPos + 4'd1;
            end
            else if (sclQ && !scl && phase != pIdle)
            begin
                if (bitPos == 4'd8)
                begin
                    // ack slot opens
                    acked      <= ackEnable && (phase != pAddr || rxByte[7:1] == `MPU_DEV_ADDR);
                    sdaPullLow <= (phase != pRead) && ackEnable
                                  && (phase != pAddr || rxByte[7:1] == `MPU_DEV_ADDR);
                end
                else if (bitPos == 4'd9)
                begin
                    sdaPullLow <= 1'b0;
                    bitPos     <= '0;
                    if (phase == pRead)
                    begin
                        ptr   <= ptr + 8'd1;                  // master nack ends the read
                        phase <= pIdle;
                    end
                    else if (!acked)
                    begin
                        phase <= pIdle;
                    end
                    else if (phase == pAddr)
                    begin
                        if (rxByte[0])
                        begin
                            txByte     <= regs[ptr[6:0]];
                            sdaPullLow <= ~regs[ptr[6:0]][7]; // first data bit
                            phase      <= pRead;
                        end
                        else
                        begin
                            phase <= pReg;
                        end
                    end
                    else if (phase == pReg)
                    begin
                        ptr   <= rxByte;
                        phase <= pWrite;
                    end
                    else
                    begin
                        regs[ptr[6:0]] <= rxByte;
                        ptr            <= ptr + 8'd1;
                    end
                end
                else if (phase == pRead)
                begin
                    sdaPullLow <= ~txByte[3'd7 - bitPos[2:0]];
                end
            end
        end
    end

endmodule

//--- rtl/i2cRegMaster.sv
// I2C register master
`include "mpuReader_cfg.svh"

module i2cRegMaster
(
    input  logic                  I_Clk_in,
    input  logic                  I_Rst_n,
    input  logic                  reqValid,
    output logic                  reqReady,
    input  mpuReader_pkg::i2cReqT req,
    output logic                  rspValid,
    output mpuReader_pkg::i2cRspT rsp,
    output logic                  scl,
    output logic                  sdaPullLow,    // 1 drives the line low
    input  logic                  sdaIn          // resolved line level
);

    localparam mpuReader_pkg::i2cAddrT devAddr = `MPU_DEV_ADDR;

    mpuReader_pkg::masterStateT state;
    mpuReader_pkg::sclCountT    sclCnt;         // position inside the current bit
    mpuReader_pkg::i2cReqT      reqLat;         // request copy, requester is free
    mpuReader_pkg::dataByteT    shiftReg;       // tx bits out msb first, rx bits in lsb
    logic [2:0]                 bitCnt;
    logic [1:0]                 byteNum;        // 0 addr+w, 1 reg, 2 data, 3 addr+r
    logic                       nackSeen;
    logic                       atSetup;
    logic                       atSample;
    logic                       atStart;
    logic                       atStop;

    ////////////////////////////////////////
    // scl divider
    ////////////////////////////////////////
    always_ff @(posedge I_Clk_in or negedge I_Rst_n)
    begin
        if (!I_Rst_n)
        begin
            sclCnt <= '0;
        end
        else if (state == mpuReader_pkg::idle || state == mpuReader_pkg::done)
        begin
            sclCnt <= '0;                                       // parked in high half
        end
        else if (sclCnt == mpuReader_pkg::sclCountT'(`MPU_SCL_DIV - 1))
        begin
            sclCnt <= '0;
        end
        else
        begin
            sclCnt <= sclCnt + mpuReader_pkg::sclCountT'(1);
        end
    end

    assign scl      = (sclCnt <= mpuReader_pkg::sclCountT'(`MPU_SCL_HIGH_END));
    assign atSetup  = (sclCnt == mpuReader_pkg::sclCountT'(`MPU_SDA_SETUP));
    assign atSample = (sclCnt == mpuReader_pkg::sclCountT'(`MPU_SAMPLE_POINT));
    assign atStart  = (sclCnt == mpuReader_pkg::sclCountT'(`MPU_START_POINT));
    assign atStop   = (sclCnt == mpuReader_pkg::sclCountT'(`MPU_STOP_POINT));

    // request capture
    always_ff @(posedge I_Clk_in)
    begin
        if (reqValid && reqReady)
        begin
            reqLat <= req;
        end
    end

    ////////////////////////////////////////
    // transaction FSM
    ////////////////////////////////////////
    always_ff @(posedge I_Clk_in or negedge I_Rst_n)
    begin
        if (!I_Rst_n)
        begin
            state      <= mpuReader_pkg::idle;
            shiftReg   <= '0;
            bitCnt     <= '0;
            byteNum    <= '0;
            nackSeen   <= 1'b0;
            sdaPullLow <= 1'b0;
        end
        else
        begin
            case (state)
                mpuReader_pkg::idle:
                begin
                    if (reqValid)                               // ready is high here
                    begin
                        nackSeen <= 1'b0;
                        bitCnt   <= '0;
                        byteNum  <= 2'd0;
                        state    <= mpuReader_pkg::start;
                    end
                end
                mpuReader_pkg::start:
                begin
                    if (atStart)
                    begin
                        sdaPullLow <= 1'b1;                     // start, sda falls under high scl
                        shiftReg   <= {devAddr, 1'b0};          // write direction first
                        state      <= mpuReader_pkg::sendByte;
                    end
                end
                mpuReader_pkg::sendByte:
                begin
                    if (atSetup)
                    begin
                        sdaPullLow <= ~shiftReg[7];             // open drain, 1 means release
                        shiftReg   <= {shiftReg[6:0], 1'b0};
                        bitCnt     <= bitCnt + 3'd1;            // wraps to 0 after bit 8
                        if (bitCnt == 3'd7)
                        begin
                            state <= mpuReader_pkg::ackRelease;
                        end
                    end
                end
                mpuReader_pkg::ackRelease:
                begin
                    if (atSetup)
                    begin
                        sdaPullLow <= 1'b0;                     // hand sda to the slave
                        state      <= mpuReader_pkg::ackSample;
                    end
                end
                mpuReader_pkg::ackSample:
                begin
                    if (atSample)
                    begin
                        if (sdaIn)
                        begin
                            nackSeen <= 1'b1;                   // abandon, close the bus
                            state    <= mpuReader_pkg::stop;
                        end
                        else
                        begin
                            case (byteNum)
                                2'd0:
                                begin
                                    shiftReg <= reqLat.regAddr;
                                    byteNum  <= 2'd1;
                                    state    <= mpuReader_pkg::sendByte;
                                end
                                2'd1:
                                begin
                                    if (reqLat.read)
                                    begin
                                        byteNum <= 2'd3;
                                        state   <= mpuReader_pkg::restart;
                                    end
                                    else
                                    begin
                                        shiftReg <= reqLat.wrData;
                                        byteNum  <= 2'd2;
                                        state    <= mpuReader_pkg::sendByte;
                                    end
                                end
                                2'd2:    state <= mpuReader_pkg::stop;     // write complete
                                default: state <= mpuReader_pkg::readByte; // addr+r acked
                            endcase
                        end
                    end
                end
                mpuReader_pkg::restart:
                begin
                    if (atSetup)
                    begin
                        sdaPullLow <= 1'b0;                     // sda high before scl rises
                    end
                    else if (atStart)
                    begin
                        sdaPullLow <= 1'b1;                     // repeated start
                        shiftReg   <= {devAddr, 1'b1};
                        state      <= mpuReader_pkg::sendByte;
                    end
                end
                mpuReader_pkg::readByte:
                begin
                    if (atSample)
                    begin
                        shiftReg <= {shiftReg[6:0], sdaIn};     // msb arrives first
                        bitCnt   <= bitCnt + 3'd1;
                        if (bitCnt == 3'd7)
                        begin
                            state <= mpuReader_pkg::masterNack;
                        end
                    end
                end
                mpuReader_pkg::masterNack:
                begin
                    if (atSetup)
                    begin
                        sdaPullLow <= 1'b0;                     // nack ends a single byte read
                        state      <= mpuReader_pkg::stop;
                    end
                end
                mpuReader_pkg::stop:
                begin
                    if (atSetup)
                    begin
                        sdaPullLow <= 1'b1;                     // low first, then rise under scl
                    end
                    else if (atStop && sdaPullLow)
                    begin
                        sdaPullLow <= 1'b0;
                        state      <= mpuReader_pkg::done;
                    end
                end
                mpuReader_pkg::done:
                begin
                    state <= mpuReader_pkg::idle;               // one cycle response strobe
                end
                default:
                begin
                    state <= mpuReader_pkg::idle;
                end
            endcase
        end
    end

    assign reqReady   = (state == mpuReader_pkg::idle);
    assign rspValid   = (state == mpuReader_pkg::done);
    assign rsp.rdData = shiftReg;
    assign rsp.nack   = nackSeen;

endmodule

//--- rtl/mpuReaderTop.sv
// Motion sensor reader top
module mpuReaderTop
(
    input  logic                       I_Clk_in,
    input  logic                       I_Rst_n,
    output logic                       scl,
    output logic                       sdaPullLow,    // pad forms the wired-and
    input  logic                       sdaIn,
    output logic                       sampleValid,
    input  logic                       sampleReady,
    output mpuReader_pkg::accelSampleT sample
);

    logic                  reqValid;
    logic                  reqReady;
    mpuReader_pkg::i2cReqT req;
    logic                  rspValid;       // strobe, always taken
    mpuReader_pkg::i2cRspT rsp;

    // wake and polling control
    mpuSampleSequencer seq0
    (
        .I_Clk_in    (I_Clk_in),
        .I_Rst_n     (I_Rst_n),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .rspValid    (rspValid),
        .rsp         (rsp),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .sample      (sample)
    );

    // byte level bus engine
    i2cRegMaster master0
    (
        .I_Clk_in   (I_Clk_in),
        .I_Rst_n    (I_Rst_n),
        .reqValid   (reqValid),
        .reqReady   (reqReady),
        .req        (req),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .scl        (scl),
        .sdaPullLow (sdaPullLow),
        .sdaIn      (sdaIn)
    );

endmodule

//--- rtl/mpuReader_cfg.svh
// Motion sensor reader configuration
`ifndef MPU_READER_CFG_SVH
`define MPU_READER_CFG_SVH

////////////////////////////////////////
// bus timing, counts within one scl period
////////////////////////////////////////
`define MPU_SCL_DIV        40                         // sys clocks per scl bit, sim value
`define MPU_SCL_HIGH_END   (`MPU_SCL_DIV / 2 - 1)     // counts 0..19 keep scl high
`define MPU_SDA_SETUP      (`MPU_SCL_DIV * 3 / 4)     // data edge, middle of low half
`define MPU_SAMPLE_POINT   (`MPU_SCL_DIV / 4)         // middle of high half
`define MPU_START_POINT    6                          // sda falls here for start
`define MPU_STOP_POINT     14                         // sda rises here for stop

////////////////////////////////////////
// sensor map
////////////////////////////////////////
`define MPU_DEV_ADDR       7'h68                      // ad0 strapped low
`define MPU_REG_PWR        8'h6B                      // pwr_mgmt_1
`define MPU_REG_ACCEL      8'h3B                      // accel_xout_h, first of six
`define MPU_ACCEL_BYTES    6                          // x, y, z, high byte first

`endif

//--- rtl/mpuReader_pkg.sv
// Motion sensor reader types
`include "mpuReader_cfg.svh"

package mpuReader_pkg;

    typedef logic [6:0]                        i2cAddrT;   // 7-bit device address
    typedef logic [7:0]                        regAddrT;   // sensor register index
    typedef logic [7:0]                        dataByteT;
    typedef logic signed [15:0]                axisT;      // two's complement reading
    typedef logic [$clog2(`MPU_SCL_DIV)-1:0]  sclCountT;  // position inside a bit

    // one register transaction
    typedef struct packed {
        logic     read;      // 1 reads a byte, 0 writes wrData
        regAddrT  regAddr;
        dataByteT wrData;
    } i2cReqT;

    typedef struct packed {
        dataByteT rdData;    // valid for reads only
        logic     nack;      // some ack slot saw sda high
    } i2cRspT;

    typedef struct packed {
        axisT accX;
        axisT accY;
        axisT accZ;
        logic err;           // one of the six reads was nacked
    } accelSampleT;

    typedef enum logic [3:0] {
        idle, start, sendByte, ackRelease, ackSample,
        restart, readByte, masterNack, stop, done
    } masterStateT;

    typedef enum logic [2:0] {wakeReq, wakeWait, readReq, readWait, present} seqStateT;

endpackage

//--- rtl/mpuSampleSequencer.sv
// Accelerometer sample sequencer
`include "mpuReader_cfg.svh"

module mpuSampleSequencer
(
    input  logic                       I_Clk_in,
    input  logic                       I_Rst_n,
    output logic                       reqValid,
    input  logic                       reqReady,
    output mpuReader_pkg::i2cReqT      req,
    input  logic                       rspValid,
    input  mpuReader_pkg::i2cRspT      rsp,
    output logic                       sampleValid,
    input  logic                       sampleReady,
    output mpuReader_pkg::accelSampleT sample
);

    mpuReader_pkg::seqStateT    state;
    mpuReader_pkg::accelSampleT sampleReg;
    logic [2:0]                 byteIdx;       // 0..5 from accel_xout_h
    logic                       isWake;

    ////////////////////////////////////////
    // request payload
    ////////////////////////////////////////
    assign isWake      = (state == mpuReader_pkg::wakeReq || state == mpuReader_pkg::wakeWait);
    assign req.read    = ~isWake;
    assign req.regAddr = isWake ? `MPU_REG_PWR
                                : mpuReader_pkg::regAddrT'(`MPU_REG_ACCEL + byteIdx);
    assign req.wrData  = mpuReader_pkg::dataByteT'(0);  // clears sleep, internal osc

    // sample assembly, big endian shift
    always_ff @(posedge I_Clk_in)
    begin
        if (state == mpuReader_pkg::readWait && rspValid)
        begin
            {sampleReg.accX, sampleReg.accY, sampleReg.accZ} <=
                {sampleReg.accX[7:0], sampleReg.accY, sampleReg.accZ, rsp.rdData};
            sampleReg.err <= (byteIdx == 3'd0) ? rsp.nack : (sampleReg.err | rsp.nack);
        end
    end

    ////////////////////////////////////////
    // sequencer FSM
    ////////////////////////////////////////
    always_ff @(posedge I_Clk_in or negedge I_Rst_n)
    begin
        if (!I_Rst_n)
        begin
            state    <= mpuReader_pkg::wakeReq;
            reqValid <= 1'b0;
            byteIdx  <= '0;
        end
        else
        begin
            case (state)
                mpuReader_pkg::wakeReq:
                begin
                    if (reqValid && reqReady)
                    begin
                        reqValid <= 1'b0;
                        state    <= mpuReader_pkg::wakeWait;
                    end
                    else
                    begin
                        reqValid <= 1'b1;                       // first cycle out of reset
                    end
                end
                mpuReader_pkg::wakeWait:
                begin
                    if (rspValid)
                    begin
                        reqValid <= 1'b1;                       // retry wake on nack
                        byteIdx  <= '0;
                        state    <= rsp.nack ? mpuReader_pkg::wakeReq : mpuReader_pkg::readReq;
                    end
                end
                mpuReader_pkg::readReq:
                begin
                    if (reqValid && reqReady)
                    begin
                        reqValid <= 1'b0;
                        state    <= mpuReader_pkg::readWait;
                    end
                end
                mpuReader_pkg::readWait:
                begin
                    if (rspValid)
                    begin
                        if (byteIdx == 3'(`MPU_ACCEL_BYTES - 1))
                        begin
                            state <= mpuReader_pkg::present;    // nack only marks err
                        end
                        else
                        begin
                            byteIdx  <= byteIdx + 3'd1;
                            reqValid <= 1'b1;
                            state    <= mpuReader_pkg::readReq;
                        end
                    end
                end
                mpuReader_pkg::present:
                begin
                    if (sampleReady)                            // no bus traffic until taken
                    begin
                        byteIdx  <= '0;
                        reqValid <= 1'b1;
                        state    <= mpuReader_pkg::readReq;
                    end
                end
                default:
                begin
                    state <= mpuReader_pkg::wakeReq;
                end
            endcase
        end
    end

    assign sampleValid = (state == mpuReader_pkg::present);
    assign sample      = sampleReg;

endmodule
